/* verilog/mpmc_pkg.sv */
package mpmc_pkg;

	// ========================================================================
	// word and address widths
	// ========================================================================
	typedef logic [31:0] data_t;
	typedef logic [3:0]  sel_t;
	// word address into the shared memory
	typedef logic [9:0]  addr_t;
	// index of a slave port, wide enough for NUM_PORTS
	typedef logic [1:0]  port_id_t;

	// ========================================================================
	// sizes
	// ========================================================================
	localparam int NUM_PORTS       = 3;
	localparam int MEM_WORDS       = 1024;
	// 16 posted writes per port
	localparam int WBUF_DEPTH_LOG2 = 4;
	// one buffered write is {adr, sel, dat}
	localparam int WBUF_WID        = $bits(addr_t) + $bits(sel_t) + $bits(data_t);

	// arbiter sequencing, one memory access per grant
	typedef enum logic [1:0] {ARB_IDLE, ARB_ACCESS, ARB_DONE} arb_state_e;

endpackage

/* verilog/mpmc_req_if.sv */
interface mpmc_req_if;

	// request side, driven by the port
	// req and the fields stay stable until done
	logic             req;
	logic             we;
	mpmc_pkg::addr_t  adr;
	mpmc_pkg::sel_t   sel;
	mpmc_pkg::data_t  dat_w;

	// response side, driven by the arbiter
	// gnt covers the whole access, done is a single cycle pulse
	logic             gnt;
	logic             done;
	// read word, valid with done
	mpmc_pkg::data_t  dat_r;

	modport port (
		output req, we, adr, sel, dat_w,
		input  gnt, done, dat_r
	);

	modport arb (
		input  req, we, adr, sel, dat_w,
		output gnt, done, dat_r
	);

endinterface

/* verilog/mpmc_fifo.sv */
module mpmc_fifo #(
	parameter int WID = 8
) (
	input  logic                               rclk,
	input  logic                               rrst,
	input  logic                               wr,
	input  logic [WID-1:0]                     di,
	input  logic                               rd,
	output logic [WID-1:0]                     dout,
	output logic [mpmc_pkg::WBUF_DEPTH_LOG2:0] cnt
);

	// storage has no reset, only the pointers are cleared
	logic [WID-1:0] ram [2**mpmc_pkg::WBUF_DEPTH_LOG2];

	// pointers carry one extra wrap bit
	logic [mpmc_pkg::WBUF_DEPTH_LOG2:0] wr_ptr;
	logic [mpmc_pkg::WBUF_DEPTH_LOG2:0] rd_ptr;
	logic full;
	logic empty;

	// fill count straight from the pointer difference
	// the wrap bit keeps full (16) apart from empty (0)
	assign cnt   = wr_ptr - rd_ptr;
	assign full  = cnt[mpmc_pkg::WBUF_DEPTH_LOG2];
	assign empty = (cnt == '0);

	// write side, a push into a full buffer is dropped
	always_ff @(posedge rclk) begin
		if (rrst) begin
			wr_ptr <= '0;
		end else if (wr && !full) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge rclk) begin
		if (wr && !full) begin
			ram[wr_ptr[mpmc_pkg::WBUF_DEPTH_LOG2-1:0]] <= di;
		end
	end

	// read side, pop only when something is there
	always_ff @(posedge rclk) begin
		if (rrst) begin
			rd_ptr <= '0;
		end else if (rd && !empty) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// oldest entry shown without a read cycle
	assign dout = ram[rd_ptr[mpmc_pkg::WBUF_DEPTH_LOG2-1:0]];

endmodule

/* verilog/mpmc_port.sv */
module mpmc_port (
	input  logic            rclk,
	input  logic            rrst,
	// wishbone classic slave
	input  logic            cyc,
	input  logic            stb,
	input  logic            we,
	input  mpmc_pkg::addr_t adr,
	input  mpmc_pkg::sel_t  sel,
	input  mpmc_pkg::data_t dat_w,
	output mpmc_pkg::data_t dat_r,
	output logic            ack,
	// request towards the arbiter
	mpmc_req_if.port        mreq
);

	logic [mpmc_pkg::WBUF_WID-1:0]        wb_head;
	logic [mpmc_pkg::WBUF_DEPTH_LOG2:0]   wb_cnt;
	mpmc_pkg::addr_t                      h_adr;
	mpmc_pkg::sel_t                       h_sel;
	mpmc_pkg::data_t                      h_dat;
	logic wb_full;
	logic draining;
	logic acc_end;
	logic wr_push;
	logic wr_done;
	logic rd_done;
	logic rd_pend;
	logic ack_q;

	// ========================================================================
	// posted write buffer
	// ========================================================================
	mpmc_fifo #(
		.WID (mpmc_pkg::WBUF_WID)
	) u_wbuf (
		.rclk (rclk),
		.rrst (rrst),
		.wr   (wr_push),
		.di   ({adr, sel, dat_w}),
		.rd   (wr_done),
		.dout (wb_head),
		.cnt  (wb_cnt)
	);

	// head entry split back into its fields
	assign {h_adr, h_sel, h_dat} = wb_head;
	assign wb_full  = wb_cnt[mpmc_pkg::WBUF_DEPTH_LOG2];
	assign draining = (wb_cnt != '0);

	// new write accepted once per bus cycle, held off while full
	assign wr_push = cyc && stb && we && !ack_q && !wb_full;

	// end of our own memory access
	// while the buffer holds entries every access is a drain
	assign acc_end = mreq.gnt && mreq.done;
	assign wr_done = acc_end && draining;
	assign rd_done = acc_end && !draining;

	// ========================================================================
	// request to the arbiter
	// ========================================================================
	// drain first, a pending read goes out only on an empty buffer
	assign mreq.req   = draining || rd_pend;
	assign mreq.we    = draining;
	assign mreq.adr   = draining ? h_adr : adr;
	assign mreq.sel   = draining ? h_sel : sel;
	// read accesses ignore the write word
	assign mreq.dat_w = h_dat;

	// ========================================================================
	// bus cycle control
	// ========================================================================
	always_ff @(posedge rclk) begin
		if (rrst) begin
			rd_pend <= 1'b0;
			ack_q   <= 1'b0;
		end else begin
			// one ack per bus cycle, either a posted write or a finished read
			ack_q <= wr_push || rd_done;
			if (rd_done) begin
				rd_pend <= 1'b0;
			end else if (cyc && stb && !we && !ack_q) begin
				rd_pend <= 1'b1;
			end
		end
	end

	// read word held for the ack cycle
	always_ff @(posedge rclk) begin
		if (rd_done) begin
			dat_r <= mreq.dat_r;
		end
	end

	assign ack = ack_q;

endmodule

/* verilog/mpmc_arbiter.sv */
module mpmc_arbiter (
	input  logic              rclk,
	input  logic              rrst,
	mpmc_req_if.arb           preq [mpmc_pkg::NUM_PORTS],
	// memory side
	output logic              mem_en,
	output logic              mem_we,
	output mpmc_pkg::sel_t    mem_sel,
	output mpmc_pkg::addr_t   mem_adr,
	output mpmc_pkg::data_t   mem_dat_w,
	input  mpmc_pkg::data_t   mem_dat_r
);

	mpmc_pkg::arb_state_e state;
	mpmc_pkg::port_id_t   last;
	mpmc_pkg::port_id_t   pick;
	logic [mpmc_pkg::NUM_PORTS-1:0] req_vec;
	logic [mpmc_pkg::NUM_PORTS-1:0] we_vec;
	mpmc_pkg::addr_t adr_arr [mpmc_pkg::NUM_PORTS];
	mpmc_pkg::sel_t  sel_arr [mpmc_pkg::NUM_PORTS];
	mpmc_pkg::data_t dat_arr [mpmc_pkg::NUM_PORTS];
	logic busy;

	// ========================================================================
	// per port fan in and fan out
	// ========================================================================
	for (genvar g = 0; g < mpmc_pkg::NUM_PORTS; g++) begin : g_port
		assign req_vec[g] = preq[g].req;
		assign we_vec[g]  = preq[g].we;
		assign adr_arr[g] = preq[g].adr;
		assign sel_arr[g] = preq[g].sel;
		assign dat_arr[g] = preq[g].dat_w;
		// grant spans access and done
		assign preq[g].gnt   = busy && (last == mpmc_pkg::port_id_t'(g));
		assign preq[g].done  = (state == mpmc_pkg::ARB_DONE) &&
			(last == mpmc_pkg::port_id_t'(g));
		assign preq[g].dat_r = preq[g].gnt ? mem_dat_r : '0;
	end

	// round robin, search starts just after the last winner
	// walk downwards so the nearest requester is written last
	always_comb begin : rr_pick
		int cand;
		pick = last;
		for (int k = mpmc_pkg::NUM_PORTS; k >= 1; k--) begin
			cand = (int'(last) + k) % mpmc_pkg::NUM_PORTS;
			if (req_vec[cand]) begin
				pick = mpmc_pkg::port_id_t'(cand);
			end
		end
	end

	// idle -> access -> done, three cycles per grant
	always_ff @(posedge rclk) begin
		if (rrst) begin
			state <= mpmc_pkg::ARB_IDLE;
			// port 0 wins first after reset
			last  <= mpmc_pkg::port_id_t'(mpmc_pkg::NUM_PORTS - 1);
		end else begin
			case (state)
				mpmc_pkg::ARB_IDLE: begin
					if (|req_vec) begin
						last  <= pick;
						state <= mpmc_pkg::ARB_ACCESS;
					end
				end
				mpmc_pkg::ARB_ACCESS: state <= mpmc_pkg::ARB_DONE;
				default:              state <= mpmc_pkg::ARB_IDLE;
			endcase
		end
	end

	assign busy = (state != mpmc_pkg::ARB_IDLE);

	// memory driven only in the access cycle
	assign mem_en    = (state == mpmc_pkg::ARB_ACCESS);
	assign mem_we    = mem_en && we_vec[last];
	assign mem_sel   = sel_arr[last];
	assign mem_adr   = adr_arr[last];
	assign mem_dat_w = dat_arr[last];

endmodule

/* verilog/mpmc_mem.sv */
module mpmc_mem (
	input  logic            rclk,
	input  logic            en,
	input  logic            we,
	input  mpmc_pkg::sel_t  sel,
	input  mpmc_pkg::addr_t adr,
	input  mpmc_pkg::data_t dat_w,
	output mpmc_pkg::data_t dat_r
);

	// shared word array, contents survive reset
	mpmc_pkg::data_t ram [mpmc_pkg::MEM_WORDS];

	always_ff @(posedge rclk) begin
		if (en) begin
			// byte lanes written independently
			if (we) begin
				for (int i = 0; i < $bits(mpmc_pkg::sel_t); i++) begin
					if (sel[i]) begin
						ram[adr][8*i +: 8] <= dat_w[8*i +: 8];
					end
				end
			end
			// registered read, old word on a write cycle
			dat_r <= ram[adr];
		end
	end

endmodule

/* verilog/mpmc_top.sv */
module mpmc_top (
	input  logic            rclk,
	input  logic            rrst,
	// port 0
	input  logic            p0_cyc,
	input  logic            p0_stb,
	input  logic            p0_we,
	input  mpmc_pkg::addr_t p0_adr,
	input  mpmc_pkg::sel_t  p0_sel,
	input  mpmc_pkg::data_t p0_dat_w,
	output mpmc_pkg::data_t p0_dat_r,
	output logic            p0_ack,
	// port 1
	input  logic            p1_cyc,
	input  logic            p1_stb,
	input  logic            p1_we,
	input  mpmc_pkg::addr_t p1_adr,
	input  mpmc_pkg::sel_t  p1_sel,
	input  mpmc_pkg::data_t p1_dat_w,
	output mpmc_pkg::data_t p1_dat_r,
	output logic            p1_ack,
	// port 2
	input  logic            p2_cyc,
	input  logic            p2_stb,
	input  logic            p2_we,
	input  mpmc_pkg::addr_t p2_adr,
	input  mpmc_pkg::sel_t  p2_sel,
	input  mpmc_pkg::data_t p2_dat_w,
	output mpmc_pkg::data_t p2_dat_r,
	output logic            p2_ack
);

	// memory bus out of the arbiter
	logic            mem_en;
	logic            mem_we;
	mpmc_pkg::sel_t  mem_sel;
	mpmc_pkg::addr_t mem_adr;
	mpmc_pkg::data_t mem_dat_w;
	mpmc_pkg::data_t mem_dat_r;

	// one request channel per port
	mpmc_req_if u_req [mpmc_pkg::NUM_PORTS] ();

	// ========================================================================
	// slave ports
	// ========================================================================
	mpmc_port u_port0 (
		.rclk (rclk), .rrst (rrst),
		.cyc (p0_cyc), .stb (p0_stb), .we (p0_we), .adr (p0_adr), .sel (p0_sel),
		.dat_w (p0_dat_w), .dat_r (p0_dat_r), .ack (p0_ack),
		.mreq (u_req[0])
	);

	mpmc_port u_port1 (
		.rclk (rclk), .rrst (rrst),
		.cyc (p1_cyc), .stb (p1_stb), .we (p1_we), .adr (p1_adr), .sel (p1_sel),
		.dat_w (p1_dat_w), .dat_r (p1_dat_r), .ack (p1_ack),
		.mreq (u_req[1])
	);

	mpmc_port u_port2 (
		.rclk (rclk), .rrst (rrst),
		.cyc (p2_cyc), .stb (p2_stb), .we (p2_we), .adr (p2_adr), .sel (p2_sel),
		.dat_w (p2_dat_w), .dat_r (p2_dat_r), .ack (p2_ack),
		.mreq (u_req[2])
	);

	// ========================================================================
	// arbiter and shared memory
	// ========================================================================
	mpmc_arbiter u_arb (
		.rclk      (rclk),
		.rrst      (rrst),
		.preq      (u_req),
		.mem_en    (mem_en),
		.mem_we    (mem_we),
		.mem_sel   (mem_sel),
		.mem_adr   (mem_adr),
		.mem_dat_w (mem_dat_w),
		.mem_dat_r (mem_dat_r)
	);

	mpmc_mem u_mem (
		.rclk  (rclk),
		.en    (mem_en),
		.we    (mem_we),
		.sel   (mem_sel),
		.adr   (mem_adr),
		.dat_w (mem_dat_w),
		.dat_r (mem_dat_r)
	);

endmodule

/* verification/mpmc_checker.sv */
module mpmc_checker (
	input  logic            rclk,
	input  logic            rrst,
	// watched top level Wishbone ports
	input  logic            cyc       [mpmc_pkg::NUM_PORTS],
	input  logic            stb       [mpmc_pkg::NUM_PORTS],
	input  logic            we        [mpmc_pkg::NUM_PORTS],
	input  mpmc_pkg::addr_t adr       [mpmc_pkg::NUM_PORTS],
	input  mpmc_pkg::sel_t  sel       [mpmc_pkg::NUM_PORTS],
	input  mpmc_pkg::data_t dat_w     [mpmc_pkg::NUM_PORTS],
	input  mpmc_pkg::data_t dat_r     [mpmc_pkg::NUM_PORTS],
	input  logic            ack       [mpmc_pkg::NUM_PORTS],
	// expected word from the data file
	input  mpmc_pkg::data_t exp_dat   [mpmc_pkg::NUM_PORTS],
	input  logic            use_model [mpmc_pkg::NUM_PORTS],
	output int              n_data_err,
	output int              n_proto_err,
	output int              n_reads
);

	timeunit 1ns;
	timeprecision 1ps;

	// shadow of the shared memory, ports use disjoint regions
	mpmc_pkg::data_t shadow [mpmc_pkg::MEM_WORDS];

	initial begin
		n_data_err  = 0;
		n_proto_err = 0;
		n_reads     = 0;
	end

	// ========================================================================
	// sample every port on the rising edge
	// ========================================================================
	always @(posedge rclk) begin
		mpmc_pkg::data_t want;
		for (int p = 0; p < mpmc_pkg::NUM_PORTS; p++) begin
			if (!rrst) begin
				if (ack[p] === 1'b1 && !(cyc[p] && stb[p])) begin
					// ack with no bus cycle, also covers the idle time after reset
					n_proto_err++;
					$display("port %0d raised ack without an active bus cycle at %0t", p, $time);
				end else if (ack[p] === 1'b1 && we[p]) begin
					// posted write, merge the enabled lanes
					for (int i = 0; i < $bits(mpmc_pkg::sel_t); i++) begin
						if (sel[p][i]) begin
							shadow[adr[p]][8*i +: 8] = dat_w[p][8*i +: 8];
						end
					end
				end else if (ack[p] === 1'b1) begin
					want = use_model[p] ? shadow[adr[p]] : exp_dat[p];
					n_reads++;
					if (dat_r[p] !== want) begin
						n_data_err++;
						$display("[FAIL] p%0d_dat_r got 0x%08h exp 0x%08h at adr 0x%03h",
							p, dat_r[p], want, adr[p]);
					end
				end else if (ack[p] !== 1'b0) begin
					n_proto_err++;
					$display("port %0d drives an unknown ack at %0t", p, $time);
				end
			end
		end
	end

endmodule

/* verification/mpmc_tb.sv */
module mpmc_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// room for the directed and random records of the data file
	localparam int          MAX_REC = 64;
	localparam int          REC_LEN = 6;
	localparam logic [31:0] SEED    = 32'h663560c6;
	// each random block writes this many words before the mixed traffic
	localparam int          RND_WIN = 16;

	logic            rclk;
	logic            rrst;
	logic            cyc       [mpmc_pkg::NUM_PORTS];
	logic            stb       [mpmc_pkg::NUM_PORTS];
	logic            we        [mpmc_pkg::NUM_PORTS];
	mpmc_pkg::addr_t adr       [mpmc_pkg::NUM_PORTS];
	mpmc_pkg::sel_t  sel       [mpmc_pkg::NUM_PORTS];
	mpmc_pkg::data_t dat_w     [mpmc_pkg::NUM_PORTS];
	mpmc_pkg::data_t dat_r     [mpmc_pkg::NUM_PORTS];
	logic            ack       [mpmc_pkg::NUM_PORTS];
	// expected read word of the current cycle
	// all ones selects the model
	mpmc_pkg::data_t exp_dat   [mpmc_pkg::NUM_PORTS];
	logic            use_model [mpmc_pkg::NUM_PORTS];

	// records are port, op, adr, sel, dat, exp
	logic [31:0] pat [0:MAX_REC*REC_LEN-1];
	int n_rec;
	int limit_cycles = 0;
	int n_data_err;
	int n_proto_err;
	int n_reads;

	// ========================================================================
	// DUT and checker
	// ========================================================================
	mpmc_top u_dut (
		.rclk (rclk), .rrst (rrst),
		.p0_cyc (cyc[0]), .p0_stb (stb[0]), .p0_we (we[0]), .p0_adr (adr[0]),
		.p0_sel (sel[0]), .p0_dat_w (dat_w[0]), .p0_dat_r (dat_r[0]), .p0_ack (ack[0]),
		.p1_cyc (cyc[1]), .p1_stb (stb[1]), .p1_we (we[1]), .p1_adr (adr[1]),
		.p1_sel (sel[1]), .p1_dat_w (dat_w[1]), .p1_dat_r (dat_r[1]), .p1_ack (ack[1]),
		.p2_cyc (cyc[2]), .p2_stb (stb[2]), .p2_we (we[2]), .p2_adr (adr[2]),
		.p2_sel (sel[2]), .p2_dat_w (dat_w[2]), .p2_dat_r (dat_r[2]), .p2_ack (ack[2])
	);

	mpmc_checker u_chk (
		.rclk (rclk), .rrst (rrst),
		.cyc (cyc), .stb (stb), .we (we), .adr (adr), .sel (sel),
		.dat_w (dat_w), .dat_r (dat_r), .ack (ack),
		.exp_dat (exp_dat), .use_model (use_model),
		.n_data_err (n_data_err), .n_proto_err (n_proto_err), .n_reads (n_reads)
	);

	initial begin
		rclk = 1'b0;
		forever #50 rclk = ~rclk;
	end

	// xorshift32 step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// one classic cycle with the fields held through the ack cycle
	task automatic do_access(input int p, input logic w, input mpmc_pkg::addr_t a,
		input mpmc_pkg::sel_t s, input mpmc_pkg::data_t d, input mpmc_pkg::data_t e);
		cyc[p]       = 1'b1;
		stb[p]       = 1'b1;
		we[p]        = w;
		adr[p]       = a;
		sel[p]       = s;
		dat_w[p]     = d;
		exp_dat[p]   = e;
		use_model[p] = (e === '1);
		do begin
			@(posedge rclk);
			#10;
		end while (ack[p] !== 1'b1);
		@(posedge rclk);
		#10;
	endtask

	// walk this port's records in file order
	task automatic run_port(input int p);
		logic [31:0] rng;
		mpmc_pkg::addr_t base;
		mpmc_pkg::sel_t s;
		int r;
		rng = SEED ^ p;
		// random window inside the port's own 256 words
		base = mpmc_pkg::addr_t'(p * 256 + 'h80);
		for (r = 0; r < n_rec; r++) begin
			if (pat[r*REC_LEN] == p) begin
				if (pat[r*REC_LEN+1] == 2) begin
					// prefill so that every random read hits a known word
					for (int k = 0; k < RND_WIN; k++) begin
						rng = xorshift32(rng);
						do_access(p, 1'b1, base + k, 4'hf, rng, '1);
					end
					for (int k = 0; k < pat[r*REC_LEN+4]; k++) begin
						rng = xorshift32(rng);
						s = rng[8:5];
						if (s == '0) begin
							s = 4'hf;
						end
						do_access(p, rng[0], base + rng[4:1], s, xorshift32(rng), '1);
						rng = xorshift32(rng);
					end
				end else begin
					do_access(p, pat[r*REC_LEN+1][0], pat[r*REC_LEN+2][9:0],
						pat[r*REC_LEN+3][3:0], pat[r*REC_LEN+4], pat[r*REC_LEN+5]);
				end
			end
		end
		cyc[p] = 1'b0;
		stb[p] = 1'b0;
	endtask

	// ========================================================================
	// main sequence
	// ========================================================================
	initial begin
		rrst = 1'b1;
		for (int p = 0; p < mpmc_pkg::NUM_PORTS; p++) begin
			cyc[p]       = 1'b0;
			stb[p]       = 1'b0;
			we[p]        = 1'b0;
			adr[p]       = '0;
			sel[p]       = '0;
			dat_w[p]     = '0;
			exp_dat[p]   = '0;
			use_model[p] = 1'b0;
		end
		$readmemh("verification/mpmc_patterns.txt", pat);
		n_rec = 0;
		while (n_rec < MAX_REC && !$isunknown(pat[n_rec*REC_LEN])) begin
			n_rec++;
		end
		limit_cycles = n_rec * 200;
		repeat (5) @(posedge rclk);
		#10;
		rrst = 1'b0;
		// idle with stb low while the checker watches for a stray ack
		repeat (5) @(posedge rclk);
		#10;
		fork
			run_port(0);
			run_port(1);
			run_port(2);
		join
		repeat (5) @(posedge rclk);
		$display("closing: %0d reads checked, %0d data errors, %0d protocol errors",
			n_reads, n_data_err, n_proto_err);
		if (n_data_err == 0 && n_proto_err == 0 && n_reads > 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// watchdog ends the run when a port never gets its ack
	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge rclk);
		$display("watchdog: not every bus cycle was acked within %0d cycles", limit_cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* verification/mpmc_patterns.txt */
// port op adr sel dat exp, op 0 read, 1 write, 2 random block of dat accesses
// exp ffffffff takes the read word from the shadow model
0 1 010 f deadbeef ffffffff
0 0 010 f 00000000 deadbeef
0 1 020 f 11223344 ffffffff
0 1 020 2 0000aa00 ffffffff
0 1 020 8 cc000000 ffffffff
0 0 020 f 00000000 cc22aa44
0 1 030 f 0badf00d ffffffff
0 0 030 f 00000000 0badf00d
0 1 031 f 5a5a0001 ffffffff
0 1 030 1 000000ee ffffffff
0 0 030 f 00000000 0badf0ee
0 2 000 0 00000028 ffffffff
1 1 140 f 10000000 ffffffff
1 1 141 f 10000001 ffffffff
1 1 140 f 10000002 ffffffff
1 1 141 f 10000003 ffffffff
1 1 140 f 10000004 ffffffff
1 1 141 f 10000005 ffffffff
1 1 140 f 10000006 ffffffff
1 1 141 f 10000007 ffffffff
1 1 140 f 10000008 ffffffff
1 1 141 f 10000009 ffffffff
1 1 140 f 1000000a ffffffff
1 1 141 f 1000000b ffffffff
1 1 140 f 1000000c ffffffff
1 1 141 f 1000000d ffffffff
1 1 140 f 1000000e ffffffff
1 1 141 f 1000000f ffffffff
1 1 140 f 10000010 ffffffff
1 1 141 f 10000011 ffffffff
1 1 140 f 10000012 ffffffff
1 1 141 f 10000013 ffffffff
1 0 140 f 00000000 10000012
1 0 141 f 00000000 10000013
1 2 000 0 00000020 ffffffff
2 1 2f0 f a5a5a5a5 ffffffff
2 0 2f0 f 00000000 a5a5a5a5
2 2 000 0 00000030 ffffffff

/* mpmc_lite.f */
verilog/mpmc_pkg.sv
verilog/mpmc_req_if.sv
verilog/mpmc_fifo.sv
verilog/mpmc_port.sv
verilog/mpmc_arbiter.sv
verilog/mpmc_mem.sv
verilog/mpmc_top.sv
verification/mpmc_checker.sv
verification/mpmc_tb.sv

/* Bender.yml */
package:
  name: mpmc_lite

sources:
  - files:
      - verilog/mpmc_pkg.sv
      - verilog/mpmc_req_if.sv
      - verilog/mpmc_fifo.sv
      - verilog/mpmc_port.sv
      - verilog/mpmc_arbiter.sv
      - verilog/mpmc_mem.sv
      - verilog/mpmc_top.sv
  - target: test
    files:
      - verification/mpmc_checker.sv
      - verification/mpmc_tb.sv
